//--- all.f
design/llc_hm_pkg.sv
design/llc_tag_way.sv
design/llc_lookup_ctrl.sv
design/llc_way_select.sv
design/llc_hit_miss_top.sv
verif/tb_hit_miss.sv

//--- design/llc_hit_miss_top.sv
// llc hit/miss stage top: controller, way array and selector
module llc_hit_miss_top
  import llc_hm_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  // descriptor input
  input  desc_t      desc_i,
  input  logic       valid_i,
  output logic       ready_o,
  // partition table entries
  input  partition_t partition_i,
  input  partition_t share_i,
  // routed descriptor, shared by both paths
  output out_desc_t  out_desc_o,
  output logic       hit_valid_o,
  input  logic       hit_ready_i,
  output logic       miss_valid_o,
  input  logic       miss_ready_i
);

  // controller side
  way_req_t way_req;
  desc_t    held_desc;
  logic     busy;
  logic     clr_valid;
  index_t   clr_index;
  // selector side
  logic     retire;
  way_upd_t upd;
  logic     upd_valid;
  // results collected from the ways
  way_res_t way_res [NUM_WAYS];

  llc_lookup_ctrl i_ctrl (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .desc_i      ( desc_i      ),
    .valid_i     ( valid_i     ),
    .ready_o     ( ready_o     ),
    .partition_i ( partition_i ),
    .share_i     ( share_i     ),
    .retire_i    ( retire      ),
    .req_o       ( way_req     ),
    .desc_o      ( held_desc   ),
    .busy_o      ( busy        ),
    .clr_valid_o ( clr_valid   ),
    .clr_index_o ( clr_index   )
  );

  // identical ways, each picks its own bit of the update one-hot
  for (genvar g = 0; g < NUM_WAYS; g++) begin : gen_way
    llc_tag_way i_way (
      .clk_i       ( clk_i      ),
      .rst_n_i     ( rst_n_i    ),
      .req_i       ( way_req    ),
      .upd_i       ( upd        ),
      .upd_valid_i ( upd_valid  ),
      .way_sel_i   ( upd.way[g] ),
      .clr_valid_i ( clr_valid  ),
      .clr_index_i ( clr_index  ),
      .res_o       ( way_res[g] )
    );
  end

  llc_way_select i_select (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .desc_i       ( held_desc    ),
    .req_i        ( way_req      ),
    .busy_i       ( busy         ),
    .res_i        ( way_res      ),
    .out_desc_o   ( out_desc_o   ),
    .hit_valid_o  ( hit_valid_o  ),
    .hit_ready_i  ( hit_ready_i  ),
    .miss_valid_o ( miss_valid_o ),
    .miss_ready_i ( miss_ready_i ),
    .retire_o     ( retire       ),
    .upd_o        ( upd          ),
    .upd_valid_o  ( upd_valid    )
  );

endmodule

//--- design/llc_hm_pkg.sv
// llc hit/miss stage package: widths, vector types, bus structs and controller states
package llc_hm_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and sizes
  ////////////////////////////////////////////////////////////////////////////

  // byte address of the request
  localparam int ADDR_W   = 16;
  // 16-byte cache lines
  localparam int OFFSET_W = 4;
  // set index width and number of sets
  localparam int INDEX_W  = 4;
  localparam int NUM_SETS = 16;
  // associativity
  localparam int NUM_WAYS = 4;
  // full line address, the index bits stay in the tag so aliased lines never match
  localparam int TAG_W    = ADDR_W - OFFSET_W;
  // transaction id
  localparam int ID_W     = 4;

  ////////////////////////////////////////////////////////////////////////////
  // vector types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [INDEX_W-1:0]  index_t;
  typedef logic [TAG_W-1:0]    tag_t;
  typedef logic [ID_W-1:0]     id_t;
  // one-hot over the ways
  typedef logic [NUM_WAYS-1:0] way_ind_t;

  ////////////////////////////////////////////////////////////////////////////
  // structs
  ////////////////////////////////////////////////////////////////////////////

  // incoming cache descriptor, rw high means write
  typedef struct packed {
    addr_t addr;
    logic  rw;
    id_t   id;
  } desc_t;

  // partition table entry, a zero num_index marks an empty partition
  typedef struct packed {
    index_t start_index;
    index_t num_index;
  } partition_t;

  // lookup broadcast to every way
  typedef struct packed {
    index_t index;
    tag_t   tag;
  } way_req_t;

  // per-way lookup result
  typedef struct packed {
    logic hit;
    logic valid;
    logic dirty;
    tag_t tag;
  } way_res_t;

  // write command, only the way whose one-hot bit is set takes it
  typedef struct packed {
    way_ind_t way;
    index_t   index;
    tag_t     tag;
    logic     dirty;
    logic     clear;
  } way_upd_t;

  // descriptor leaving on the hit or the miss path
  typedef struct packed {
    desc_t    desc;
    way_ind_t way_ind;
    logic     refill;
    logic     evict;
    tag_t     evict_tag;
  } out_desc_t;

  // controller states
  typedef enum logic [1:0] {
    INIT,
    IDLE,
    BUSY
  } ctrl_state_e;

endpackage

//--- design/llc_lookup_ctrl.sv
// lookup controller: init sweep of the tag store, descriptor intake and partitioned set mapping
module llc_lookup_ctrl
  import llc_hm_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  // descriptor input
  input  desc_t      desc_i,
  input  logic       valid_i,
  output logic       ready_o,
  // partition entries, sampled with the descriptor
  input  partition_t partition_i,
  input  partition_t share_i,
  // output transfer from the selector
  input  logic       retire_i,
  // held lookup towards ways and selector
  output way_req_t   req_o,
  output desc_t      desc_o,
  output logic       busy_o,
  // init clear path to the ways
  output logic       clr_valid_o,
  output index_t     clr_index_o
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  index_t      init_cnt_q;
  logic        accept;
  index_t      addr_field;
  index_t      mapped_index;
  way_req_t    req_q;
  desc_t       desc_q;

  // start of the partition plus the field folded into its size
  function automatic index_t map_index(input index_t field, input partition_t part);
    index_t offset;
    if (part.num_index == '0) begin
      offset = field;
    end else begin
      offset = field % part.num_index;
    end
    // index_t addition wraps at NUM_SETS
    return part.start_index + offset;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // handshake and index mapping
  ////////////////////////////////////////////////////////////////////////////

  // idle takes a descriptor, busy only in the cycle the held one leaves
  assign ready_o = (state_q == IDLE) || ((state_q == BUSY) && retire_i);
  assign accept  = valid_i && ready_o;

  // raw set field sits right above the line offset
  assign addr_field = desc_i.addr[OFFSET_W +: INDEX_W];

  // own partition first, shared partition when ours is empty
  assign mapped_index = (partition_i.num_index != '0) ? map_index(addr_field, partition_i)
                                                     : map_index(addr_field, share_i);

  ////////////////////////////////////////////////////////////////////////////
  // state machine
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      INIT: begin
        // one set cleared per cycle, leave after the last one
        if (init_cnt_q == index_t'(NUM_SETS - 1)) begin
          state_d = IDLE;
        end
      end
      IDLE: begin
        if (accept) begin
          state_d = BUSY;
        end
      end
      BUSY: begin
        // back-to-back intake keeps us busy
        if (retire_i && !accept) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = INIT;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= INIT;
      init_cnt_q <= '0;
    end else begin
      state_q <= state_d;
      // counter wraps back to zero as init ends
      if (state_q == INIT) begin
        init_cnt_q <= init_cnt_q + 1'b1;
      end
    end
  end

  // held descriptor and lookup, loaded on acceptance only
  always_ff @(posedge clk_i) begin
    if (accept) begin
      desc_q      <= desc_i;
      req_q.index <= mapped_index;
      req_q.tag   <= desc_i.addr[ADDR_W-1:OFFSET_W];
    end
  end

  assign req_o  = req_q;
  assign desc_o = desc_q;
  assign busy_o = (state_q == BUSY);

  // clear sweep drives the counter as set address
  assign clr_valid_o = (state_q == INIT);
  assign clr_index_o = init_cnt_q;

  // no descriptor slips in during the sweep
  a_no_accept_in_init : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    accept |-> (state_q != INIT))
    else $error("descriptor accepted during init");

endmodule

//--- design/llc_tag_way.sv
// tag way: valid, dirty and tag storage for every set of one way, with lookup compare
module llc_tag_way
  import llc_hm_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,
  // lookup of the held descriptor
  input  way_req_t req_i,
  // write command from the selector
  input  way_upd_t upd_i,
  input  logic     upd_valid_i,
  // this way's bit of the update one-hot
  input  logic     way_sel_i,
  // init sweep
  input  logic     clr_valid_i,
  input  index_t   clr_index_i,
  output way_res_t res_o
);

  logic [NUM_SETS-1:0] valid_q;
  logic [NUM_SETS-1:0] dirty_q;
  tag_t                tag_q [NUM_SETS];
  logic                wr_en;
  tag_t                rd_tag;
  logic                rd_valid;

  // only commands aimed at this way write
  assign wr_en = upd_valid_i && way_sel_i;

  ////////////////////////////////////////////////////////////////////////////
  // storage
  ////////////////////////////////////////////////////////////////////////////

  // valid bits per set, dropped by reset and by the init sweep
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
    end else if (clr_valid_i) begin
      valid_q[clr_index_i] <= 1'b0;
    end else if (wr_en) begin
      // clear flag drops the line instead of filling it
      valid_q[upd_i.index] <= !upd_i.clear;
    end
  end

  // dirty and tag follow the same write paths
  always_ff @(posedge clk_i) begin
    if (clr_valid_i) begin
      dirty_q[clr_index_i] <= 1'b0;
      tag_q[clr_index_i]   <= '0;
    end else if (wr_en) begin
      dirty_q[upd_i.index] <= upd_i.dirty;
      tag_q[upd_i.index]   <= upd_i.tag;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // lookup
  ////////////////////////////////////////////////////////////////////////////

  // read port addressed by the held request
  assign rd_valid = valid_q[req_i.index];
  assign rd_tag   = tag_q[req_i.index];

  always_comb begin
    res_o.valid = rd_valid;
    res_o.dirty = dirty_q[req_i.index];
    res_o.tag   = rd_tag;
    // full line compare, stale tags of invalid lines never hit
    res_o.hit   = rd_valid && (rd_tag == req_i.tag);
  end

endmodule

//--- design/llc_way_select.sv
// way selector: hit or victim choice, hit/miss routing and the write back to the ways
module llc_way_select
  import llc_hm_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_n_i,
  // held descriptor and lookup
  input  desc_t     desc_i,
  input  way_req_t  req_i,
  input  logic      busy_i,
  // results of all ways
  input  way_res_t  res_i [NUM_WAYS],
  // shared output descriptor
  output out_desc_t out_desc_o,
  output logic      hit_valid_o,
  input  logic      hit_ready_i,
  output logic      miss_valid_o,
  input  logic      miss_ready_i,
  // pulse on output transfer
  output logic      retire_o,
  // write command to the ways
  output way_upd_t  upd_o,
  output logic      upd_valid_o
);

  way_ind_t hit_vec;
  way_ind_t free_way;
  way_ind_t victim;
  way_ind_t rr_q;
  logic     hit;
  logic     has_free;
  way_res_t hit_res;
  way_res_t victim_res;
  logic     hit_xfer;
  logic     miss_xfer;

  ////////////////////////////////////////////////////////////////////////////
  // way reduction
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    hit_vec  = '0;
    free_way = '0;
    // walk down so the lowest invalid way wins
    for (int w = NUM_WAYS - 1; w >= 0; w--) begin
      hit_vec[w] = res_i[w].hit;
      if (!res_i[w].valid) begin
        free_way = way_ind_t'(1) << w;
      end
    end
  end

  assign hit      = |hit_vec;
  assign has_free = |free_way;

  // invalid way first, round-robin pointer once the set is full
  assign victim = has_free ? free_way : rr_q;

  // pick out the stored state of the hit way and of the victim
  always_comb begin
    hit_res    = '0;
    victim_res = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (hit_vec[w]) begin
        hit_res = res_i[w];
      end
      if (victim[w]) begin
        victim_res = res_i[w];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output descriptor and handshake
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    out_desc_o.desc    = desc_i;
    out_desc_o.way_ind = hit ? hit_vec : victim;
    // every miss refills
    out_desc_o.refill  = !hit;
    // write back needed only for a valid dirty victim
    out_desc_o.evict   = !hit && victim_res.valid && victim_res.dirty;
    out_desc_o.evict_tag = hit ? '0 : victim_res.tag;
  end

  // the store does not change while held, so the path stays put
  assign hit_valid_o  = busy_i && hit;
  assign miss_valid_o = busy_i && !hit;

  assign hit_xfer  = hit_valid_o && hit_ready_i;
  assign miss_xfer = miss_valid_o && miss_ready_i;
  assign retire_o  = hit_xfer || miss_xfer;

  // update lands on the same edge the next request loads
  always_comb begin
    upd_o.way   = out_desc_o.way_ind;
    upd_o.index = req_i.index;
    upd_o.tag   = req_i.tag;
    // hit keeps old dirty and adds a write, a fill takes the write bit
    upd_o.dirty = hit ? (hit_res.dirty || desc_i.rw) : desc_i.rw;
    upd_o.clear = 1'b0;
  end

  assign upd_valid_o = retire_o;

  // round-robin pointer, moves only when a valid line is replaced
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q <= way_ind_t'(1);
    end else if (miss_xfer && !has_free) begin
      rr_q <= {rr_q[NUM_WAYS-2:0], rr_q[NUM_WAYS-1]};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // a line lives in at most one way of its set
  a_hit_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    busy_i |-> $onehot0(hit_vec))
    else $error("hit vector not one-hot: %h", hit_vec);

  a_single_path : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(hit_valid_o && miss_valid_o))
    else $error("hit and miss valid both high");

  // stalled output holds its path and its payload
  a_hold_stall : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (busy_i && !retire_o) |=> busy_i && $stable(out_desc_o) && $stable(hit_valid_o))
    else $error("output changed under back-pressure");

endmodule

//--- run.sh
#!/bin/sh
# build the hit/miss stage testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_hit_miss -f all.f -o vtb_hit_miss || exit 1
sim_out=$(./obj_dir/vtb_hit_miss 2>&1)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -q "Verification passed" && exit 0 || exit 1

//--- verif/hit_miss_golden.txt
# addr rw id part_start part_num share_start share_num miss way refill evict evict_tag
# all hex, miss 1 means the miss output, way is one-hot
# first touch of set 1, then repeat and write hit
0010 0 1 0 8 8 8 1 1 1 0 000
0010 0 2 0 8 8 8 0 1 0 0 000
0018 1 3 0 8 8 8 0 1 0 0 000
# index fields 9 and 1 alias into set 1
0090 0 4 0 8 8 8 1 2 1 0 000
1010 1 5 0 8 8 8 1 4 1 0 000
# empty partition falls back to the share entry, set 9
0010 0 6 0 0 8 8 1 1 1 0 000
0090 0 7 0 0 8 8 1 2 1 0 000
# fill set 1 and walk the round-robin victim
2010 0 8 0 8 8 8 1 8 1 0 000
3010 0 9 0 8 8 8 1 1 1 1 001
0010 1 a 0 8 8 8 1 2 1 0 009
# write hit makes way 3 dirty before it is evicted
2014 1 b 0 8 8 8 0 8 0 0 000
4010 0 c 0 8 8 8 1 4 1 1 101
5010 0 d 0 8 8 8 1 8 1 1 201
0010 0 e 0 8 8 8 0 2 0 0 000
6010 1 f 0 8 8 8 1 1 1 0 301
7010 0 0 0 8 8 8 1 2 1 1 001
# partition of three sets from 12, fields 5 2 8 11 land in set 14
0050 0 1 c 3 8 8 1 1 1 0 000
0020 1 2 c 3 8 8 1 2 1 0 000
0080 0 3 c 3 8 8 1 4 1 0 000
00b0 1 4 c 3 8 8 1 8 1 0 000
# start 14 plus 3 wraps to set 1
0030 0 5 e 4 8 8 1 4 1 0 401
0020 0 6 c 3 8 8 0 2 0 0 000
00e0 0 7 c 3 8 8 1 8 1 1 00b
0110 0 8 c 3 8 8 1 1 1 0 000
# set 9 through the share entry
0010 1 9 0 0 8 8 0 1 0 0 000
0190 0 a 0 0 8 8 1 4 1 0 000
0290 0 b 0 0 8 8 1 8 1 0 000
0390 0 c 0 0 8 8 1 1 1 1 001
0090 0 d 0 0 8 8 0 2 0 0 000
# back to set 1, full round of evictions
6018 0 e 0 8 8 8 0 1 0 0 000
8010 1 f 0 8 8 8 1 2 1 0 701
9010 0 0 0 8 8 8 1 4 1 0 003
a010 0 1 0 8 8 8 1 8 1 0 501
b010 0 2 0 8 8 8 1 1 1 1 601
c010 0 3 0 8 8 8 1 2 1 1 801
8010 0 4 0 8 8 8 1 4 1 0 901

//--- verif/tb_hit_miss.sv
// testbench for the llc hit/miss stage: golden file stimulus, random output stalls, result checks
module tb_hit_miss
  import llc_hm_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // cycle limits, one per kind of wait
  localparam int INIT_TIMEOUT   = 4 * NUM_SETS;
  localparam int ACCEPT_TIMEOUT = 64;
  localparam int RESULT_TIMEOUT = 64;
  localparam int DRAIN_TIMEOUT  = 256;

  logic        clk_i = 1'b0;
  logic        rst_n_i;
  desc_t       desc_i;
  logic        valid_i;
  logic        ready_o;
  partition_t  partition_i;
  partition_t  share_i;
  out_desc_t   out_desc_o;
  logic        hit_valid_o;
  logic        hit_ready_i = 1'b0;
  logic        miss_valid_o;
  logic        miss_ready_i = 1'b0;

  // expected results in input order, queued before the descriptor is offered
  out_desc_t   exp_desc_q [$];
  logic        exp_miss_q [$];
  int          sent = 0;
  int          received = 0;

  // back-pressure source
  logic [31:0] lfsr_q = 32'hc9f8;
  logic        stall_a;
  logic        stall_b;

  llc_hit_miss_top dut_i (
    .clk_i        ( clk_i        ),
    .rst_n_i      ( rst_n_i      ),
    .desc_i       ( desc_i       ),
    .valid_i      ( valid_i      ),
    .ready_o      ( ready_o      ),
    .partition_i  ( partition_i  ),
    .share_i      ( share_i      ),
    .out_desc_o   ( out_desc_o   ),
    .hit_valid_o  ( hit_valid_o  ),
    .hit_ready_i  ( hit_ready_i  ),
    .miss_valid_o ( miss_valid_o ),
    .miss_ready_i ( miss_ready_i )
  );

  // 100 ns period
  always #50 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Verification failed");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_out_desc(input string name, input out_desc_t got, input out_desc_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL %s got %h exp %h", name, got, exp));
    end
  endtask

  // got is high when the miss valid carried the descriptor
  task automatic check_path(input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("FAIL miss_valid_o got %h exp %h", got, exp));
    end
  endtask

  // galois lfsr, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
      nxt = nxt ^ 32'h8020_0003;
    end
    return nxt;
  endfunction

  // each ready drops when two fresh bits are both set, about one cycle in four
  always @(negedge clk_i) begin
    lfsr_q = lfsr_next(lfsr_q);
    stall_a = lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
    stall_b = lfsr_q[0];
    hit_ready_i = !(stall_a && stall_b);
    lfsr_q = lfsr_next(lfsr_q);
    stall_a = lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
    stall_b = lfsr_q[0];
    miss_ready_i = !(stall_a && stall_b);
  end

  ////////////////////////////////////////////////////////////////////////////
  // output monitor
  ////////////////////////////////////////////////////////////////////////////

  // sampled on the rising edge, before the DUT registers update
  initial begin : monitor
    logic      hv;
    logic      mv;
    logic      xfer;
    logic      stalled;
    logic      stall_miss;
    out_desc_t stall_desc;
    out_desc_t exp_desc;
    logic      exp_miss;
    int        pending;
    int        wait_cycles;

    stalled     = 1'b0;
    stall_miss  = 1'b0;
    stall_desc  = '0;
    pending     = 0;
    wait_cycles = 0;
    forever begin
      @(posedge clk_i);
      if (rst_n_i) begin
        hv = hit_valid_o;
        mv = miss_valid_o;
        if (hv && mv) begin
          abort_run("hit_valid_o and miss_valid_o are high in the same cycle");
        end
        if (pending > 0 && !(hv || mv)) begin
          abort_run("no output valid while a descriptor is in flight");
        end
        if (pending == 0 && (hv || mv)) begin
          abort_run("output valid raised with no descriptor in flight");
        end
        // a stalled output must hold its path and payload
        if (stalled) begin
          check_path(mv, stall_miss);
          check_out_desc("out_desc_o", out_desc_o, stall_desc);
        end
        xfer = (hv && hit_ready_i) || (mv && miss_ready_i);
        if (xfer) begin
          if (exp_desc_q.size() == 0) begin
            abort_run("output transfer with no expected result left");
          end
          exp_desc = exp_desc_q.pop_front();
          exp_miss = exp_miss_q.pop_front();
          check_path(mv, exp_miss);
          check_out_desc("out_desc_o", out_desc_o, exp_desc);
          received++;
          wait_cycles = 0;
        end else if (hv || mv) begin
          wait_cycles++;
          if (wait_cycles > RESULT_TIMEOUT) begin
            abort_run("output held valid too long without a transfer");
          end
        end
        stalled    = (hv || mv) && !xfer;
        stall_miss = mv;
        stall_desc = out_desc_o;
        pending    = pending - int'(xfer) + int'(valid_i && ready_o);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // reset, init and stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin : driver
    int          fd;
    int          rc;
    int          fields;
    int          cycles;
    int          ready_low;
    logic        seen;
    string       line;
    // addr rw id part_start part_num share_start share_num miss way refill evict evict_tag
    logic [31:0] col [12];
    out_desc_t   exp_desc;

    rst_n_i     = 1'b0;
    valid_i     = 1'b0;
    desc_i      = '0;
    partition_i = '0;
    share_i     = '0;
    fd = $fopen("verif/hit_miss_golden.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open the golden file verif/hit_miss_golden.txt");
    end
    repeat (3) @(negedge clk_i);
    rst_n_i = 1'b1;

    // init sweep, ready_o must stay low for one cycle per set
    ready_low = 0;
    seen      = 1'b0;
    while (!seen) begin
      @(posedge clk_i);
      if (hit_valid_o || miss_valid_o) begin
        abort_run("output valid raised during the init sweep");
      end
      if (ready_o) begin
        seen = 1'b1;
      end else begin
        ready_low++;
        if (ready_low > INIT_TIMEOUT) begin
          abort_run("ready_o never rose after reset");
        end
      end
    end
    if (ready_low != NUM_SETS) begin
      abort_run($sformatf("FAIL ready_o low cycles got %h exp %h", ready_low, NUM_SETS));
    end

    // one golden line per descriptor, lines starting with # are skipped
    while ($feof(fd) == 0) begin
      rc = $fgets(line, fd);
      if (rc > 0 && line.len() > 1 && line.getc(0) != "#") begin
        fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                         col[0], col[1], col[2], col[3], col[4], col[5],
                         col[6], col[7], col[8], col[9], col[10], col[11]);
        if (fields != 12) begin
          abort_run("golden line does not hold twelve fields");
        end
        @(negedge clk_i);
        desc_i.addr             = addr_t'(col[0]);
        desc_i.rw               = col[1][0];
        desc_i.id               = id_t'(col[2]);
        partition_i.start_index = index_t'(col[3]);
        partition_i.num_index   = index_t'(col[4]);
        share_i.start_index     = index_t'(col[5]);
        share_i.num_index       = index_t'(col[6]);
        exp_desc.desc           = desc_i;
        exp_desc.way_ind        = way_ind_t'(col[8]);
        exp_desc.refill         = col[9][0];
        exp_desc.evict          = col[10][0];
        exp_desc.evict_tag      = tag_t'(col[11]);
        exp_desc_q.push_back(exp_desc);
        exp_miss_q.push_back(col[7][0]);
        valid_i = 1'b1;
        // hold until taken
        seen   = 1'b0;
        cycles = 0;
        while (!seen) begin
          @(posedge clk_i);
          if (ready_o) begin
            seen = 1'b1;
          end else begin
            cycles++;
            if (cycles > ACCEPT_TIMEOUT) begin
              abort_run($sformatf("descriptor %0d was never accepted", sent));
            end
          end
        end
        sent++;
      end
    end
    $fclose(fd);
    @(negedge clk_i);
    valid_i = 1'b0;

    // drain the last results
    cycles = 0;
    while (received != sent) begin
      @(negedge clk_i);
      cycles++;
      if (cycles > DRAIN_TIMEOUT) begin
        abort_run("results still missing after the last descriptor");
      end
    end
    if (sent > 0 && exp_desc_q.size() == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      abort_run("no descriptor was run or expected results were left over");
    end
  end

endmodule
